/* unicore_uncore.f */
design/uncore_msg_pkg.sv
design/uncore_map_pkg.sv
design/two_entry_fifo.sv
design/cmd_router.sv
design/resp_router.sv
design/clint_slice.sv
design/cfg_regs.sv
design/unicore_uncore.sv
sim/unicore_uncore_properties.sv
sim/tb_unicore_uncore.sv

/* Bender.yml */
package:
  name: unicore_uncore

sources:
  - files:
      - design/uncore_msg_pkg.sv
      - design/uncore_map_pkg.sv
      - design/two_entry_fifo.sv
      - design/cmd_router.sv
      - design/resp_router.sv
      - design/clint_slice.sv
      - design/cfg_regs.sv
      - design/unicore_uncore.sv
  - target: test
    files:
      - sim/unicore_uncore_properties.sv
      - sim/tb_unicore_uncore.sv

/* sim/tb_unicore_uncore.sv */
module tb_unicore_uncore;

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] dram_base    = 32'h8000_0000;
  localparam logic [31:0] msip_addr     = 32'h0010_0000;
  localparam logic [31:0] mtimecmp_addr = 32'h0010_4000;
  localparam logic [31:0] mtime_addr    = 32'h0010_bff8;
  localparam logic [31:0] freeze_addr   = 32'h0020_0008;
  localparam logic [31:0] scratch_addr  = 32'h0020_0010;
  localparam logic [31:0] loop_addr     = 32'h0050_0000;

  logic clk, reset;
  logic cmd_v [2], cmd_write [2], cmd_ready [2], resp_v [2], resp_yumi [2];
  logic [31:0] cmd_addr [2];
  logic [63:0] cmd_data [2], resp_data [2];
  logic mem_cmd_v, mem_cmd_ready, mem_cmd_write, mem_cmd_src;
  logic [31:0] mem_cmd_addr;
  logic [63:0] mem_cmd_data, mem_resp_data;
  logic mem_resp_v, mem_resp_yumi, mem_resp_src;
  logic timer_irq, software_irq, freeze;

  // Memory contents, the prediction copy, and the next command each side owes memory
  logic [63:0] mem_array [logic [31:0]];
  logic [63:0] shadow [logic [31:0]];
  logic [96:0] mem_exp [2];
  logic mem_exp_v [2];
  logic [63:0] pend_data [$];
  logic pend_src [$];
  int pend_due [$];
  int mismatch_cnt = 0;
  int timeout_cnt = 0;

  unicore_uncore #(.timer_div_p(8)) i_dut
    (.clk_i(clk), .reset_i(reset)
     ,.icache_cmd_v_i(cmd_v[0]), .icache_cmd_ready_o(cmd_ready[0])
     ,.icache_cmd_write_i(cmd_write[0]), .icache_cmd_addr_i(cmd_addr[0])
     ,.icache_cmd_data_i(cmd_data[0]), .icache_resp_v_o(resp_v[0])
     ,.icache_resp_yumi_i(resp_yumi[0]), .icache_resp_data_o(resp_data[0])
     ,.dcache_cmd_v_i(cmd_v[1]), .dcache_cmd_ready_o(cmd_ready[1])
     ,.dcache_cmd_write_i(cmd_write[1]), .dcache_cmd_addr_i(cmd_addr[1])
     ,.dcache_cmd_data_i(cmd_data[1]), .dcache_resp_v_o(resp_v[1])
     ,.dcache_resp_yumi_i(resp_yumi[1]), .dcache_resp_data_o(resp_data[1])
     ,.mem_cmd_v_o(mem_cmd_v), .mem_cmd_ready_i(mem_cmd_ready)
     ,.mem_cmd_write_o(mem_cmd_write), .mem_cmd_addr_o(mem_cmd_addr)
     ,.mem_cmd_data_o(mem_cmd_data), .mem_cmd_src_o(mem_cmd_src)
     ,.mem_resp_v_i(mem_resp_v), .mem_resp_yumi_o(mem_resp_yumi)
     ,.mem_resp_data_i(mem_resp_data), .mem_resp_src_i(mem_resp_src)
     ,.timer_irq_o(timer_irq), .software_irq_o(software_irq), .freeze_o(freeze)
     );

  bind unicore_uncore unicore_uncore_properties i_props (.*);

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string msg, input logic [127:0] got,
                                 input logic [127:0] exp);
    mismatch_cnt++;
    $display("mismatch at %0d ns: %s, got %0h expected %0h", $time, msg, got, exp);
  endtask

  function automatic logic [63:0] mem_expect(input logic [31:0] addr);
    return shadow.exists(addr) ? shadow[addr] : {addr, ~addr};
  endfunction

  // Keeps one command outstanding and returns 2 ns after a rising edge
  task automatic access(input int port, input logic wr, input logic [31:0] addr,
                        input logic [63:0] data, output logic [63:0] rdata);
    int t;
    logic done;
    rdata = 'x;
    if (addr >= dram_base)
    begin
      mem_exp[port] = {wr, addr, data};
      mem_exp_v[port] = 1'b1;
    end
    cmd_v[port] = 1'b1;
    cmd_write[port] = wr;
    cmd_addr[port] = addr;
    cmd_data[port] = data;
    t = 0;
    done = 1'b0;
    while (!done && t < 100)
    begin
      @(negedge clk);
      done = cmd_ready[port];
      @(posedge clk);
      #2;
      t++;
    end
    cmd_v[port] = 1'b0;
    if (!done)
    begin
      timeout_cnt++;
      $display("timeout: requester %0d command to %h was never accepted", port, addr);
      return;
    end
    t = 0;
    done = 1'b0;
    while (!done && t < 200)
    begin
      // Sometimes leave a valid response waiting a cycle
      if (resp_v[port] && $urandom_range(2) != 0)
      begin
        rdata = resp_data[port];
        resp_yumi[port] = 1'b1;
        done = 1'b1;
      end
      @(posedge clk);
      #2;
      t++;
    end
    resp_yumi[port] = 1'b0;
    if (!done)
    begin
      timeout_cnt++;
      $display("timeout: requester %0d got no response for %h", port, addr);
    end
  endtask

  task automatic transact(input int port, input logic wr, input logic [31:0] addr,
                          input logic [63:0] data, input logic [63:0] exp, input string what);
    logic [63:0] got;
    access(port, wr, addr, data, got);
    assert (got === exp) else report_mismatch(what, got, exp);
  endtask

  task automatic mem_transact(input int port, input logic wr, input logic [31:0] addr,
                              input logic [63:0] data);
    logic [63:0] exp;
    exp = wr ? 64'd0 : mem_expect(addr);
    if (wr)
      shadow[addr] = data;
    transact(port, wr, addr, data, exp, wr ? "memory write" : "memory read");
  endtask

  // Each side keeps to its own DRAM words so predictions stay per requester
  task automatic random_traffic(input int port, input int count);
    logic [31:0] addr;
    logic wr;
    for (int i = 0; i < count; i++)
    begin
      wr = 1'($urandom_range(1));
      if ($urandom_range(3) == 0)
      begin
        addr = loop_addr | ($urandom_range(255) << 3);
        transact(port, wr, addr, {$urandom, $urandom}, 64'd0, "loopback under contention");
      end
      else
      begin
        addr = dram_base | (port << 8) | ($urandom_range(31) << 3);
        mem_transact(port, wr, addr, {$urandom, $urandom});
      end
    end
  endtask

  // Memory model
  initial
  begin
    logic cmd_fire, resp_fire, src_s, write_s;
    logic [31:0] addr_s;
    logic [63:0] data_s, rd;
    int cycle;
    cycle = 0;
    forever
    begin
      @(negedge clk);
      cmd_fire = mem_cmd_v && mem_cmd_ready;
      resp_fire = mem_resp_v && mem_resp_yumi;
      {write_s, addr_s, data_s, src_s} = {mem_cmd_write, mem_cmd_addr, mem_cmd_data, mem_cmd_src};
      @(posedge clk);
      #2;
      cycle++;
      if (cmd_fire)
      begin
        if (!mem_exp_v[src_s])
        begin
          mismatch_cnt++;
          $display("unexpected memory command from requester %0d at %0d ns", src_s, $time);
        end
        else
          assert ({write_s, addr_s, data_s} === mem_exp[src_s])
            else report_mismatch("memory port command", {write_s, addr_s, data_s}, mem_exp[src_s]);
        mem_exp_v[src_s] = 1'b0;
        rd = mem_array.exists(addr_s) ? mem_array[addr_s] : {addr_s, ~addr_s};
        if (write_s)
          mem_array[addr_s] = data_s;
        pend_data.push_back(write_s ? 64'd0 : rd);
        pend_src.push_back(src_s);
        pend_due.push_back(cycle + $urandom_range(1, 6));
      end
      if (resp_fire)
      begin
        pend_data.delete(0);
        pend_src.delete(0);
        pend_due.delete(0);
        mem_resp_v = 1'b0;
      end
      if (!mem_resp_v && pend_due.size() != 0 && cycle >= pend_due[0])
      begin
        mem_resp_v = 1'b1;
        mem_resp_data = pend_data[0];
        mem_resp_src = pend_src[0];
      end
      mem_cmd_ready = ($urandom_range(3) != 0);
    end
  end

  initial
  begin
    logic [63:0] t1, t2;
    int t;
    void'($urandom(248));
    reset = 1'b1;
    for (int p = 0; p < 2; p++)
    begin
      cmd_v[p] = 1'b0;
      cmd_write[p] = 1'b0;
      cmd_addr[p] = '0;
      cmd_data[p] = '0;
      resp_yumi[p] = 1'b0;
      mem_exp[p] = '0;
      mem_exp_v[p] = 1'b0;
    end
    mem_cmd_ready = 1'b1;
    mem_resp_v = 1'b0;
    mem_resp_data = '0;
    mem_resp_src = 1'b0;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    assert ({freeze, timer_irq, software_irq} === 3'b100)
      else report_mismatch("side-band outputs after reset",
                           {freeze, timer_irq, software_irq}, 3'b100);
    transact(1, 1'b1, freeze_addr, 64'd0, 64'd0, "freeze write");
    assert (freeze === 1'b0) else report_mismatch("freeze_o after clearing", freeze, 0);
    transact(0, 1'b1, scratch_addr, 64'h0123_4567_89ab_cdef, 64'd0, "scratch write");
    transact(1, 1'b0, scratch_addr, 64'd0, 64'h0123_4567_89ab_cdef, "scratch read, data side");
    transact(0, 1'b0, scratch_addr, 64'd0, 64'h0123_4567_89ab_cdef, "scratch read, instr side");
    transact(1, 1'b0, freeze_addr, 64'd0, 64'd0, "freeze read");

    transact(1, 1'b1, msip_addr, 64'd1, 64'd0, "msip write");
    assert (software_irq === 1'b1)
      else report_mismatch("software_irq_o after msip", software_irq, 1);
    transact(0, 1'b0, msip_addr, 64'd0, 64'd1, "msip read");
    access(1, 1'b0, mtime_addr, 64'd0, t1);
    access(0, 1'b0, mtime_addr, 64'd0, t2);
    assert (t2 >= t1) else report_mismatch("second mtime read below first", t2, t1);
    transact(1, 1'b1, mtimecmp_addr, t2 + 64'd4, 64'd0, "mtimecmp write");
    t = 0;
    while (!timer_irq && t < 200)
    begin
      @(posedge clk);
      #2;
      t++;
    end
    if (!timer_irq)
    begin
      timeout_cnt++;
      $display("timeout: timer interrupt did not rise after the mtimecmp write");
    end

    transact(0, 1'b0, loop_addr | 32'h100, 64'd0, 64'd0, "loopback read");
    transact(1, 1'b1, loop_addr | 32'h108, 64'h5a5a, 64'd0, "loopback write");

    mem_transact(0, 1'b0, dram_base | 32'h10, 64'd0);
    mem_transact(0, 1'b1, dram_base | 32'h18, 64'hfeed_face_cafe_beef);
    mem_transact(1, 1'b0, dram_base | 32'h18, 64'd0);

    fork
      random_traffic(0, 24);
      random_traffic(1, 24);
    join

    // Any response still pending here was never asked for
    repeat (20) @(negedge clk);
    if (resp_v[0] || resp_v[1] || mem_resp_v)
    begin
      mismatch_cnt++;
      $display("a response is still pending after every command completed");
    end

    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatch_cnt, timeout_cnt, i_dut.i_props.fail_count);
    if (mismatch_cnt == 0 && timeout_cnt == 0 && i_dut.i_props.fail_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* sim/unicore_uncore_properties.sv */
module unicore_uncore_properties
  (input                                       clk_i
   , input                                     reset_i
   , input                                     icache_cmd_v_i
   , input                                     icache_cmd_ready_o
   , input                                     icache_resp_v_o
   , input                                     icache_resp_yumi_i
   , input [uncore_msg_pkg::data_width_p-1:0]  icache_resp_data_o
   , input                                     dcache_cmd_v_i
   , input                                     dcache_cmd_ready_o
   , input                                     dcache_resp_v_o
   , input                                     dcache_resp_yumi_i
   , input [uncore_msg_pkg::data_width_p-1:0]  dcache_resp_data_o
   , input                                     mem_cmd_v_o
   , input                                     mem_cmd_ready_i
   );

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;
  logic [2:0] icache_open_r, dcache_open_r;

  // Commands taken in and not yet drained for each requester
  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        icache_open_r <= '0;
        dcache_open_r <= '0;
      end
    else
      begin
        icache_open_r <= icache_open_r + (icache_cmd_v_i & icache_cmd_ready_o)
                       - (icache_resp_v_o & icache_resp_yumi_i);
        dcache_open_r <= dcache_open_r + (dcache_cmd_v_i & dcache_cmd_ready_o)
                       - (dcache_resp_v_o & dcache_resp_yumi_i);
      end

  a_icache_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      icache_resp_v_o && !icache_resp_yumi_i |=> icache_resp_v_o && $stable(icache_resp_data_o))
    else begin $error("icache response dropped or changed before yumi"); fail_count++; end

  a_dcache_resp_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      dcache_resp_v_o && !dcache_resp_yumi_i |=> dcache_resp_v_o && $stable(dcache_resp_data_o))
    else begin $error("dcache response dropped or changed before yumi"); fail_count++; end

  // A memory command transfers in the cycle it is offered
  a_mem_cmd_ready: assert property (@(posedge clk_i) disable iff (reset_i)
      mem_cmd_v_o |-> mem_cmd_ready_i)
    else begin $error("memory command offered without ready"); fail_count++; end

  a_icache_resp_owed: assert property (@(posedge clk_i) disable iff (reset_i)
      icache_resp_v_o |-> icache_open_r != 0)
    else begin $error("icache response without an open command"); fail_count++; end

  a_dcache_resp_owed: assert property (@(posedge clk_i) disable iff (reset_i)
      dcache_resp_v_o |-> dcache_open_r != 0)
    else begin $error("dcache response without an open command"); fail_count++; end

  a_mem_idle_in_reset: assert property (@(posedge clk_i)
      reset_i && $past(reset_i) |-> !mem_cmd_v_o)
    else begin $error("memory command issued during reset"); fail_count++; end

endmodule

/* design/unicore_uncore.sv */
module unicore_uncore
 #(parameter int timer_div_p = 8)
  (input                                             clk_i
   , input                                           reset_i

   , input                                           icache_cmd_v_i
   , output logic                                    icache_cmd_ready_o
   , input                                           icache_cmd_write_i
   , input [uncore_msg_pkg::paddr_width_p-1:0]       icache_cmd_addr_i
   , input [uncore_msg_pkg::data_width_p-1:0]        icache_cmd_data_i
   , output logic                                    icache_resp_v_o
   , input                                           icache_resp_yumi_i
   , output logic [uncore_msg_pkg::data_width_p-1:0] icache_resp_data_o

   , input                                           dcache_cmd_v_i
   , output logic                                    dcache_cmd_ready_o
   , input                                           dcache_cmd_write_i
   , input [uncore_msg_pkg::paddr_width_p-1:0]       dcache_cmd_addr_i
   , input [uncore_msg_pkg::data_width_p-1:0]        dcache_cmd_data_i
   , output logic                                    dcache_resp_v_o
   , input                                           dcache_resp_yumi_i
   , output logic [uncore_msg_pkg::data_width_p-1:0] dcache_resp_data_o

   , output logic                                    mem_cmd_v_o
   , input                                           mem_cmd_ready_i
   , output logic                                    mem_cmd_write_o
   , output logic [uncore_msg_pkg::paddr_width_p-1:0] mem_cmd_addr_o
   , output logic [uncore_msg_pkg::data_width_p-1:0] mem_cmd_data_o
   , output logic [uncore_msg_pkg::src_width_p-1:0]  mem_cmd_src_o

   , input                                           mem_resp_v_i
   , output logic                                    mem_resp_yumi_o
   , input [uncore_msg_pkg::data_width_p-1:0]        mem_resp_data_i
   , input [uncore_msg_pkg::src_width_p-1:0]         mem_resp_src_i

   , output logic                                    timer_irq_o
   , output logic                                    software_irq_o
   , output logic                                    freeze_o
   );

  import uncore_msg_pkg::*;

  cmd_msg_s icache_cmd_li, dcache_cmd_li, icache_cmd_lo, dcache_cmd_lo, dev_cmd_lo;
  logic icache_cmd_v_lo, dcache_cmd_v_lo, icache_cmd_yumi_li, dcache_cmd_yumi_li;
  logic clint_cmd_v_li, clint_cmd_ready_lo, cfg_cmd_v_li, cfg_cmd_ready_lo;

  resp_msg_s loop_resp_lo, clint_resp_lo, cfg_resp_lo, mem_resp_li;
  logic loop_resp_v_lo, clint_resp_v_lo, cfg_resp_v_lo;
  logic loop_resp_yumi_li, clint_resp_yumi_li, cfg_resp_yumi_li;

  resp_msg_s icache_resp_li, dcache_resp_li, icache_resp_lo, dcache_resp_lo;
  logic icache_resp_v_li, dcache_resp_v_li, icache_resp_ready_lo, dcache_resp_ready_lo;

  // Source index comes from the port, instruction side 0 and data side 1
  assign icache_cmd_li = '{write: icache_cmd_write_i, src: src_width_p'(0)
                          , addr: icache_cmd_addr_i, data: icache_cmd_data_i};
  assign dcache_cmd_li = '{write: dcache_cmd_write_i, src: src_width_p'(1)
                          , addr: dcache_cmd_addr_i, data: dcache_cmd_data_i};
  assign mem_resp_li   = '{src: mem_resp_src_i, data: mem_resp_data_i};

  assign mem_cmd_write_o    = dev_cmd_lo.write;
  assign mem_cmd_addr_o     = dev_cmd_lo.addr.raw;
  assign mem_cmd_data_o     = dev_cmd_lo.data;
  assign mem_cmd_src_o      = dev_cmd_lo.src;
  assign icache_resp_data_o = icache_resp_lo.data;
  assign dcache_resp_data_o = dcache_resp_lo.data;

  two_entry_fifo
   #(.width_p($bits(cmd_msg_s)))
   icache_cmd_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.data_i(icache_cmd_li)
     ,.v_i(icache_cmd_v_i)
     ,.ready_o(icache_cmd_ready_o)
     ,.data_o(icache_cmd_lo)
     ,.v_o(icache_cmd_v_lo)
     ,.yumi_i(icache_cmd_yumi_li)
     );

  two_entry_fifo
   #(.width_p($bits(cmd_msg_s)))
   dcache_cmd_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.data_i(dcache_cmd_li)
     ,.v_i(dcache_cmd_v_i)
     ,.ready_o(dcache_cmd_ready_o)
     ,.data_o(dcache_cmd_lo)
     ,.v_o(dcache_cmd_v_lo)
     ,.yumi_i(dcache_cmd_yumi_li)
     );

  two_entry_fifo
   #(.width_p($bits(resp_msg_s)))
   icache_resp_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.data_i(icache_resp_li)
     ,.v_i(icache_resp_v_li)
     ,.ready_o(icache_resp_ready_lo)
     ,.data_o(icache_resp_lo)
     ,.v_o(icache_resp_v_o)
     ,.yumi_i(icache_resp_yumi_i)
     );

  two_entry_fifo
   #(.width_p($bits(resp_msg_s)))
   dcache_resp_fifo
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.data_i(dcache_resp_li)
     ,.v_i(dcache_resp_v_li)
     ,.ready_o(dcache_resp_ready_lo)
     ,.data_o(dcache_resp_lo)
     ,.v_o(dcache_resp_v_o)
     ,.yumi_i(dcache_resp_yumi_i)
     );

  cmd_router
   cmd_arb
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.icache_cmd_i(icache_cmd_lo)
     ,.icache_cmd_v_i(icache_cmd_v_lo)
     ,.icache_cmd_yumi_o(icache_cmd_yumi_li)
     ,.dcache_cmd_i(dcache_cmd_lo)
     ,.dcache_cmd_v_i(dcache_cmd_v_lo)
     ,.dcache_cmd_yumi_o(dcache_cmd_yumi_li)
     ,.dev_cmd_o(dev_cmd_lo)
     ,.clint_cmd_v_o(clint_cmd_v_li)
     ,.clint_cmd_ready_i(clint_cmd_ready_lo)
     ,.cfg_cmd_v_o(cfg_cmd_v_li)
     ,.cfg_cmd_ready_i(cfg_cmd_ready_lo)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.loop_resp_o(loop_resp_lo)
     ,.loop_resp_v_o(loop_resp_v_lo)
     ,.loop_resp_yumi_i(loop_resp_yumi_li)
     );

  resp_router
   resp_arb
    (.loop_resp_i(loop_resp_lo)
     ,.loop_resp_v_i(loop_resp_v_lo)
     ,.loop_resp_yumi_o(loop_resp_yumi_li)
     ,.mem_resp_i(mem_resp_li)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.clint_resp_i(clint_resp_lo)
     ,.clint_resp_v_i(clint_resp_v_lo)
     ,.clint_resp_yumi_o(clint_resp_yumi_li)
     ,.cfg_resp_i(cfg_resp_lo)
     ,.cfg_resp_v_i(cfg_resp_v_lo)
     ,.cfg_resp_yumi_o(cfg_resp_yumi_li)
     ,.icache_resp_o(icache_resp_li)
     ,.icache_resp_v_o(icache_resp_v_li)
     ,.icache_resp_ready_i(icache_resp_ready_lo)
     ,.dcache_resp_o(dcache_resp_li)
     ,.dcache_resp_v_o(dcache_resp_v_li)
     ,.dcache_resp_ready_i(dcache_resp_ready_lo)
     );

  clint_slice
   #(.timer_div_p(timer_div_p))
   clint
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(dev_cmd_lo)
     ,.cmd_v_i(clint_cmd_v_li)
     ,.cmd_ready_o(clint_cmd_ready_lo)
     ,.resp_o(clint_resp_lo)
     ,.resp_v_o(clint_resp_v_lo)
     ,.resp_yumi_i(clint_resp_yumi_li)
     ,.timer_irq_o(timer_irq_o)
     ,.software_irq_o(software_irq_o)
     );

  cfg_regs
   cfg
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_i(dev_cmd_lo)
     ,.cmd_v_i(cfg_cmd_v_li)
     ,.cmd_ready_o(cfg_cmd_ready_lo)
     ,.resp_o(cfg_resp_lo)
     ,.resp_v_o(cfg_resp_v_lo)
     ,.resp_yumi_i(cfg_resp_yumi_li)
     ,.freeze_o(freeze_o)
     );

endmodule

/* design/cfg_regs.sv */
module cfg_regs
  (input                               clk_i
   , input                             reset_i

   , input uncore_msg_pkg::cmd_msg_s   cmd_i
   , input                             cmd_v_i
   , output logic                      cmd_ready_o

   , output uncore_msg_pkg::resp_msg_s resp_o
   , output logic                      resp_v_o
   , input                             resp_yumi_i

   , output logic                      freeze_o
   );

  import uncore_msg_pkg::*;
  import uncore_map_pkg::*;

  logic [data_width_p-1:0] scratch_r, rdata;
  logic [19:0] offset;
  logic freeze_r, resp_v_r, accept, wr;

  assign offset      = cmd_i.addr.dev.offset;
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign wr          = accept & cmd_i.write;

  // Core comes out of reset frozen
  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        freeze_r  <= 1'b1;
        scratch_r <= '0;
      end
    else
      begin
        if (wr & (offset == freeze_offset_gp))
          freeze_r <= cmd_i.data[0];
        if (wr & (offset == scratch_offset_gp))
          scratch_r <= cmd_i.data;
      end

  assign rdata = (offset == freeze_offset_gp)  ? data_width_p'(freeze_r)
               : (offset == scratch_offset_gp) ? scratch_r
               : '0;

  always_ff @(posedge clk_i)
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;

  always_ff @(posedge clk_i)
    if (accept)
      resp_o <= '{src: cmd_i.src, data: (cmd_i.write ? '0 : rdata)};

  assign resp_v_o = resp_v_r;
  assign freeze_o = freeze_r;

endmodule

/* design/clint_slice.sv */
module clint_slice
 #(parameter int timer_div_p = 8)
  (input                               clk_i
   , input                             reset_i

   , input uncore_msg_pkg::cmd_msg_s   cmd_i
   , input                             cmd_v_i
   , output logic                      cmd_ready_o

   , output uncore_msg_pkg::resp_msg_s resp_o
   , output logic                      resp_v_o
   , input                             resp_yumi_i

   , output logic                      timer_irq_o
   , output logic                      software_irq_o
   );

  import uncore_msg_pkg::*;
  import uncore_map_pkg::*;

  localparam int div_width_lp = $clog2(timer_div_p + 1);

  logic [div_width_lp-1:0] prescale_r;
  logic [data_width_p-1:0] mtime_r, mtimecmp_r, rdata;
  logic [19:0] offset;
  logic msip_r, timer_irq_r, resp_v_r;
  logic tick, accept, wr;

  assign offset      = cmd_i.addr.dev.offset;
  assign cmd_ready_o = ~resp_v_r;
  assign accept      = cmd_v_i & cmd_ready_o;
  assign wr          = accept & cmd_i.write;
  assign tick        = (prescale_r == div_width_lp'(timer_div_p - 1));

  always_ff @(posedge clk_i)
    if (reset_i | tick)
      prescale_r <= '0;
    else
      prescale_r <= prescale_r + 1'b1;

  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        msip_r      <= 1'b0;
        mtimecmp_r  <= '1;
        mtime_r     <= '0;
        timer_irq_r <= 1'b0;
      end
    else
      begin
        if (wr & (offset == msip_offset_gp))
          msip_r <= cmd_i.data[0];
        if (wr & (offset == mtimecmp_offset_gp))
          mtimecmp_r <= cmd_i.data;
        // A software write to mtime beats the tick
        if (wr & (offset == mtime_offset_gp))
          mtime_r <= cmd_i.data;
        else if (tick)
          mtime_r <= mtime_r + 1'b1;
        timer_irq_r <= (mtime_r >= mtimecmp_r);
      end

  always_comb
    case (offset)
      msip_offset_gp:     rdata = data_width_p'(msip_r);
      mtimecmp_offset_gp: rdata = mtimecmp_r;
      mtime_offset_gp:    rdata = mtime_r;
      default:            rdata = '0;
    endcase

  always_ff @(posedge clk_i)
    if (reset_i)
      resp_v_r <= 1'b0;
    else if (accept)
      resp_v_r <= 1'b1;
    else if (resp_yumi_i)
      resp_v_r <= 1'b0;

  always_ff @(posedge clk_i)
    if (accept)
      resp_o <= '{src: cmd_i.src, data: (cmd_i.write ? '0 : rdata)};

  assign resp_v_o       = resp_v_r;
  assign timer_irq_o    = timer_irq_r;
  assign software_irq_o = msip_r;

endmodule

/* design/resp_router.sv */
module resp_router
  (input uncore_msg_pkg::resp_msg_s    loop_resp_i
   , input                             loop_resp_v_i
   , output logic                      loop_resp_yumi_o

   , input uncore_msg_pkg::resp_msg_s  mem_resp_i
   , input                             mem_resp_v_i
   , output logic                      mem_resp_yumi_o

   , input uncore_msg_pkg::resp_msg_s  clint_resp_i
   , input                             clint_resp_v_i
   , output logic                      clint_resp_yumi_o

   , input uncore_msg_pkg::resp_msg_s  cfg_resp_i
   , input                             cfg_resp_v_i
   , output logic                      cfg_resp_yumi_o

   , output uncore_msg_pkg::resp_msg_s icache_resp_o
   , output logic                      icache_resp_v_o
   , input                             icache_resp_ready_i

   , output uncore_msg_pkg::resp_msg_s dcache_resp_o
   , output logic                      dcache_resp_v_o
   , input                             dcache_resp_ready_i
   );

  import uncore_msg_pkg::*;

  localparam int w_lp = $bits(resp_msg_s);

  resp_msg_s sel;
  logic all_ready, any_grant;

  assign all_ready = icache_resp_ready_i & dcache_resp_ready_i;

  // Loopback first, then memory, interruptor, config
  assign loop_resp_yumi_o  = all_ready & loop_resp_v_i;
  assign mem_resp_yumi_o   = all_ready & mem_resp_v_i & ~loop_resp_v_i;
  assign clint_resp_yumi_o = all_ready & clint_resp_v_i & ~loop_resp_v_i & ~mem_resp_v_i;
  assign cfg_resp_yumi_o   = all_ready & cfg_resp_v_i & ~loop_resp_v_i & ~mem_resp_v_i
                           & ~clint_resp_v_i;

  assign any_grant = loop_resp_yumi_o | mem_resp_yumi_o | clint_resp_yumi_o | cfg_resp_yumi_o;

  assign sel = ({w_lp{loop_resp_yumi_o}} & loop_resp_i)
             | ({w_lp{mem_resp_yumi_o}} & mem_resp_i)
             | ({w_lp{clint_resp_yumi_o}} & clint_resp_i)
             | ({w_lp{cfg_resp_yumi_o}} & cfg_resp_i);

  // steer by source index
  assign icache_resp_o   = sel;
  assign dcache_resp_o   = sel;
  assign icache_resp_v_o = any_grant & (sel.src == src_width_p'(0));
  assign dcache_resp_v_o = any_grant & (sel.src == src_width_p'(1));

endmodule

/* design/cmd_router.sv */
module cmd_router
  (input                               clk_i
   , input                             reset_i

   , input uncore_msg_pkg::cmd_msg_s   icache_cmd_i
   , input                             icache_cmd_v_i
   , output logic                      icache_cmd_yumi_o

   , input uncore_msg_pkg::cmd_msg_s   dcache_cmd_i
   , input                             dcache_cmd_v_i
   , output logic                      dcache_cmd_yumi_o

   , output uncore_msg_pkg::cmd_msg_s  dev_cmd_o

   , output logic                      clint_cmd_v_o
   , input                             clint_cmd_ready_i
   , output logic                      cfg_cmd_v_o
   , input                             cfg_cmd_ready_i
   , output logic                      mem_cmd_v_o
   , input                             mem_cmd_ready_i

   , output uncore_msg_pkg::resp_msg_s loop_resp_o
   , output logic                      loop_resp_v_o
   , input                             loop_resp_yumi_i
   );

  import uncore_msg_pkg::*;
  import uncore_map_pkg::*;

  logic all_ready, grant, loop_accept;
  logic is_local, is_clint, is_cfg, is_loop;
  logic loop_v_r;
  logic [src_width_p-1:0] loop_src_r;

  // Conservative back-pressure, every target must be able to take the command
  assign all_ready = clint_cmd_ready_i & cfg_cmd_ready_i & mem_cmd_ready_i & ~loop_v_r;

  // Data side wins over instruction side
  assign dcache_cmd_yumi_o = all_ready & dcache_cmd_v_i;
  assign icache_cmd_yumi_o = all_ready & icache_cmd_v_i & ~dcache_cmd_v_i;
  assign grant             = dcache_cmd_yumi_o | icache_cmd_yumi_o;

  assign dev_cmd_o = ({$bits(cmd_msg_s){dcache_cmd_yumi_o}} & dcache_cmd_i)
                   | ({$bits(cmd_msg_s){icache_cmd_yumi_o}} & icache_cmd_i);

  assign is_local = (dev_cmd_o.addr.raw < dram_base_gp);
  assign is_clint = is_local & (dev_cmd_o.addr.dev.code == clint_dev_gp);
  assign is_cfg   = is_local & (dev_cmd_o.addr.dev.code == cfg_dev_gp);
  assign is_loop  = is_local & ~is_clint & ~is_cfg;

  assign clint_cmd_v_o = grant & is_clint;
  assign cfg_cmd_v_o   = grant & is_cfg;
  assign mem_cmd_v_o   = grant & ~is_local;
  assign loop_accept   = grant & is_loop;

  // Loopback answers unmapped devices with zero data
  always_ff @(posedge clk_i)
    if (reset_i)
      loop_v_r <= 1'b0;
    else if (loop_accept)
      loop_v_r <= 1'b1;
    else if (loop_resp_yumi_i)
      loop_v_r <= 1'b0;

  always_ff @(posedge clk_i)
    if (loop_accept)
      loop_src_r <= dev_cmd_o.src;

  assign loop_resp_v_o = loop_v_r;
  assign loop_resp_o   = '{src: loop_src_r, data: '0};

endmodule

/* design/two_entry_fifo.sv */
module two_entry_fifo
 #(parameter int width_p = 8)
  (input                        clk_i
   , input                      reset_i

   , input [width_p-1:0]        data_i
   , input                      v_i
   , output logic               ready_o

   , output logic [width_p-1:0] data_o
   , output logic               v_o
   , input                      yumi_i
   );

  logic [width_p-1:0] mem_r [1:0];
  logic rptr_r, wptr_r, full_r, empty_r;
  logic enq, deq;

  // A leaving entry frees its slot for an incoming one
  assign ready_o = ~full_r | yumi_i;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ready_o;
  assign deq = yumi_i & v_o;

  always_ff @(posedge clk_i)
    if (enq)
      mem_r[wptr_r] <= data_i;

  always_ff @(posedge clk_i)
    if (reset_i)
      begin
        rptr_r  <= 1'b0;
        wptr_r  <= 1'b0;
        full_r  <= 1'b0;
        empty_r <= 1'b1;
      end
    else
      begin
        if (enq)
          wptr_r <= ~wptr_r;
        if (deq)
          rptr_r <= ~rptr_r;
        if (enq & ~deq)
          begin
            empty_r <= 1'b0;
            full_r  <= (~wptr_r == rptr_r);
          end
        else if (deq & ~enq)
          begin
            full_r  <= 1'b0;
            empty_r <= (~rptr_r == wptr_r);
          end
      end

endmodule

/* design/uncore_map_pkg.sv */
package uncore_map_pkg;

  // Everything below this address is a local device
  localparam logic [31:0] dram_base_gp = 32'h8000_0000;

  localparam logic [3:0] clint_dev_gp = 4'd1;
  localparam logic [3:0] cfg_dev_gp   = 4'd2;

  // Interruptor register offsets
  localparam logic [19:0] msip_offset_gp     = 20'h00000;
  localparam logic [19:0] mtimecmp_offset_gp = 20'h04000;
  localparam logic [19:0] mtime_offset_gp    = 20'h0bff8;

  // Config block register offsets
  localparam logic [19:0] freeze_offset_gp  = 20'h00008;
  localparam logic [19:0] scratch_offset_gp = 20'h00010;

endpackage

/* design/uncore_msg_pkg.sv */
package uncore_msg_pkg;

  localparam int paddr_width_p = 32;
  localparam int data_width_p  = 64;
  localparam int src_width_p   = 1;

  // One physical address, seen whole for DRAM or split for local devices
  typedef union packed {
    logic [paddr_width_p-1:0] raw;
    struct packed {
      logic [7:0]  upper;
      logic [3:0]  code;
      logic [19:0] offset;
    } dev;
  } paddr_u;

  typedef struct packed {
    logic                    write;
    logic [src_width_p-1:0]  src;
    paddr_u                  addr;
    logic [data_width_p-1:0] data;
  } cmd_msg_s;

  // Writes come back with zero data
  typedef struct packed {
    logic [src_width_p-1:0]  src;
    logic [data_width_p-1:0] data;
  } resp_msg_s;

endpackage
